//--- compile.f
+incdir+rtl
rtl/soc_pkg.sv
rtl/mem_req_if.sv
rtl/axi_slave_port.sv
rtl/soc_mem_decode.sv
rtl/serial_out_fifo.sv
rtl/npc_soc_top.sv
sim/npc_soc_chk.sv
sim/npc_soc_tb.sv

//--- rtl/axi_slave_port.sv
`timescale 1ns/1ps

module axi_slave_port
  import soc_pkg::*;
(
  input  logic       clock,
  input  logic       rst,

  input  logic       awvalid,
  output logic       awready,
  input  axi_id_t    awid,
  input  addr_t      awaddr,
  input  axi_len_t   awlen,
  input  logic [2:0] awsize,
  input  logic [1:0] awburst,

  input  logic       wvalid,
  output logic       wready,
  input  data_t      wdata,
  input  strb_t      wstrb,
  input  logic       wlast,

  output logic       bvalid,
  input  logic       bready,
  output axi_id_t    bid,
  output axi_resp_t  bresp,

  input  logic       arvalid,
  output logic       arready,
  input  axi_id_t    arid,
  input  addr_t      araddr,
  input  axi_len_t   arlen,
  input  logic [2:0] arsize,
  input  logic [1:0] arburst,

  output logic       rvalid,
  input  logic       rready,
  output axi_id_t    rid,
  output data_t      rdata,
  output axi_resp_t  rresp,
  output logic       rlast,

  mem_req_if.port    mem
);

  // awsize, arsize and both burst types are not decoded
  // every burst runs as INCR of full words

  port_state_e state;
  logic        ready_en;

  axi_id_t     id_q;
  addr_t       addr_q;
  axi_len_t    len_q;
  axi_len_t    beat_q;
  logic        err_q;

  logic        aw_fire;
  logic        w_fire;
  logic        ar_fire;
  logic        r_fire;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;

  // write wins over read in idle
  assign awready = (state == idle) && ready_en;
  assign arready = (state == idle) && ready_en && !awvalid;

  // one W beat per accepted word request
  assign wready = (state == write_beat) && mem.gnt;

  assign bvalid = (state == write_resp);
  assign bid    = id_q;
  assign bresp  = err_q ? resp_slverr : resp_okay;

  // read data held by the decoder until the next read request
  assign rvalid = (state == read_data);
  assign rid    = id_q;
  assign rdata  = mem.rdata;
  assign rresp  = mem.err ? resp_slverr : resp_okay;
  assign rlast  = (state == read_data) && (beat_q == len_q);

  assign mem.req   = ((state == write_beat) && wvalid) || (state == read_issue);
  assign mem.we    = (state == write_beat);
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata;
  assign mem.wstrb = wstrb;

  always_ff @(posedge clock) begin
    if (rst) begin
      state    <= idle;
      ready_en <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      case (state)
        idle: begin
          if (aw_fire) begin
            state <= write_beat;
          end else if (ar_fire) begin
            state <= read_issue;
          end
        end
        write_beat: begin
          if (w_fire && wlast) begin
            state <= write_resp;
          end
        end
        write_resp: begin
          if (bready) begin
            state <= idle;
          end
        end
        read_issue: begin
          // request accepted this cycle, data follows next cycle
          if (mem.gnt) begin
            state <= read_data;
          end
        end
        read_data: begin
          if (rready) begin
            state <= rlast ? idle : read_issue;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // burst bookkeeping
  always_ff @(posedge clock) begin
    if (aw_fire) begin
      id_q   <= awid;
      addr_q <= {awaddr[31:2], 2'b00};
      len_q  <= awlen;
      beat_q <= '0;
      err_q  <= 1'b0;
    end else if (ar_fire) begin
      id_q   <= arid;
      addr_q <= {araddr[31:2], 2'b00};
      len_q  <= arlen;
      beat_q <= '0;
    end else if (w_fire) begin
      addr_q <= addr_q + 32'd4;
      beat_q <= beat_q + 8'd1;
      // sticky for the whole burst
      err_q  <= err_q | mem.err;
    end else if (r_fire) begin
      addr_q <= addr_q + 32'd4;
      beat_q <= beat_q + 8'd1;
    end
  end

endmodule

//--- rtl/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if
  import soc_pkg::*;
();

  // request side
  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;
  strb_t wstrb;

  // response side
  logic  gnt;
  data_t rdata;
  logic  err;

  modport port (
    output req, we, addr, wdata, wstrb,
    input  gnt, rdata, err
  );

  modport mem (
    input  req, we, addr, wdata, wstrb,
    output gnt, rdata, err
  );

endinterface

//--- rtl/npc_soc_top.sv
`timescale 1ns/1ps

module npc_soc_top
  import soc_pkg::*;
(
  input  logic       clock,
  input  logic       rst,

  input  logic       awvalid,
  output logic       awready,
  input  axi_id_t    awid,
  input  addr_t      awaddr,
  input  axi_len_t   awlen,
  input  logic [2:0] awsize,
  input  logic [1:0] awburst,

  input  logic       wvalid,
  output logic       wready,
  input  data_t      wdata,
  input  strb_t      wstrb,
  input  logic       wlast,

  output logic       bvalid,
  input  logic       bready,
  output axi_id_t    bid,
  output axi_resp_t  bresp,

  input  logic       arvalid,
  output logic       arready,
  input  axi_id_t    arid,
  input  addr_t      araddr,
  input  axi_len_t   arlen,
  input  logic [2:0] arsize,
  input  logic [1:0] arburst,

  output logic       rvalid,
  input  logic       rready,
  output axi_id_t    rid,
  output data_t      rdata,
  output axi_resp_t  rresp,
  output logic       rlast,

  output logic       serial_valid,
  output byte_t      serial_data,
  input  logic       serial_ready
);

  mem_req_if bus ();

  logic  push;
  byte_t push_data;
  logic  full;

  axi_slave_port u_port (
    .clock   (clock),
    .rst     (rst),
    .awvalid (awvalid),
    .awready (awready),
    .awid    (awid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awsize  (awsize),
    .awburst (awburst),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .bvalid  (bvalid),
    .bready  (bready),
    .bid     (bid),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .arid    (arid),
    .araddr  (araddr),
    .arlen   (arlen),
    .arsize  (arsize),
    .arburst (arburst),
    .rvalid  (rvalid),
    .rready  (rready),
    .rid     (rid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .mem     (bus.port)
  );

  soc_mem_decode u_decode (
    .clock     (clock),
    .rst       (rst),
    .bus       (bus.mem),
    .push      (push),
    .push_data (push_data),
    .full      (full)
  );

  serial_out_fifo u_fifo (
    .clock        (clock),
    .rst          (rst),
    .push         (push),
    .push_data    (push_data),
    .full         (full),
    .serial_valid (serial_valid),
    .serial_data  (serial_data),
    .serial_ready (serial_ready)
  );

endmodule

//--- rtl/serial_out_fifo.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module serial_out_fifo
  import soc_pkg::*;
(
  input  logic  clock,
  input  logic  rst,
  input  logic  push,
  input  byte_t push_data,
  output logic  full,
  output logic  serial_valid,
  output byte_t serial_data,
  input  logic  serial_ready
);

  localparam int depth = `SOC_SERIAL_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  byte_t            fifo_mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             pop;

  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop          = serial_valid && serial_ready;
  assign serial_valid = (count != '0);
  assign full         = (count == cnt_w'(depth));
  assign serial_data  = fifo_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // push and pop together leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      fifo_mem[wr_ptr] <= push_data;
    end
  end

endmodule

//--- rtl/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// memory window, byte address and depth in words
`define SOC_MEM_BASE 32'h8000_0000
`define SOC_MEM_WORDS 1024

// serial output port, one byte wide
`define SOC_SERIAL_ADDR 32'h1000_0000

// byte fifo toward the serial stream
`define SOC_SERIAL_DEPTH 4

`endif

//--- rtl/soc_mem_decode.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_mem_decode
  import soc_pkg::*;
(
  input  logic   clock,
  input  logic   rst,
  mem_req_if.mem bus,
  output logic   push,
  output byte_t  push_data,
  input  logic   full
);

  localparam int    mem_words = `SOC_MEM_WORDS;
  localparam int    idx_w     = $clog2(mem_words);
  localparam addr_t mem_base  = `SOC_MEM_BASE;
  localparam addr_t ser_addr  = `SOC_SERIAL_ADDR;

  data_t            mem_array [mem_words];
  addr_t            mem_off;
  logic [idx_w-1:0] word_idx;
  logic             mem_hit;
  logic             ser_hit;
  logic             unmapped;
  logic             accept;

  data_t            rd_word;
  logic             rd_hit;
  logic             rd_err;

  // unsigned offset, wraps below the base
  assign mem_off  = bus.addr - mem_base;
  assign mem_hit  = mem_off < addr_t'(mem_words * 4);
  assign word_idx = mem_off[idx_w+1:2];
  assign ser_hit  = (bus.addr[31:2] == ser_addr[31:2]);
  assign unmapped = !mem_hit && !ser_hit;

  // only a serial write can stall
  assign bus.gnt = !(bus.we && ser_hit && full);
  assign accept  = bus.req && bus.gnt;

  assign push      = accept && bus.we && ser_hit && bus.wstrb[0];
  assign push_data = bus.wdata[7:0];

  // write errors now, read errors with the data
  assign bus.err   = bus.we ? unmapped : rd_err;
  assign bus.rdata = rd_hit ? rd_word : '0;

  always_ff @(posedge clock) begin
    if (accept && bus.we && mem_hit) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (bus.wstrb[lane]) begin
          mem_array[word_idx][8*lane +: 8] <= bus.wdata[8*lane +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept && !bus.we) begin
      rd_word <= mem_array[word_idx];
    end
  end

  // target of the last read, held until the next one
  always_ff @(posedge clock) begin
    if (rst) begin
      rd_hit <= 1'b0;
      rd_err <= 1'b0;
    end else if (accept && !bus.we) begin
      rd_hit <= mem_hit;
      rd_err <= unmapped;
    end
  end

endmodule

//--- rtl/soc_pkg.sv
package soc_pkg;

  // bus vectors
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [7:0]  byte_t;

  // axi fields
  typedef logic [3:0]  axi_id_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [1:0]  axi_resp_t;

  localparam axi_resp_t resp_okay   = 2'b00;
  localparam axi_resp_t resp_slverr = 2'b10;

  // slave port fsm, one burst at a time
  typedef enum logic [2:0] {
    idle,
    write_beat,
    write_resp,
    read_issue,
    read_data
  } port_state_e;

endpackage

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass is found in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module npc_soc_tb \
  -o npc_soc_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/npc_soc_sim > sim.log 2>&1

grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- sim/npc_soc_chk.sv
`timescale 1ns/1ps

module npc_soc_chk (
  input logic        clock,
  input logic        rst,
  input logic        awready,
  input logic        arready,
  input logic        bvalid,
  input logic        bready,
  input logic [5:0]  b_payload,
  input logic        rvalid,
  input logic        rready,
  input logic [38:0] r_payload,
  input logic        push,
  input logic        full,
  input logic        serial_valid,
  input logic        serial_ready,
  input logic [7:0]  serial_data
);

  // fifo level rebuilt from the push and pop handshakes
  logic [3:0] level;

  always_ff @(posedge clock) begin
    if (rst) begin
      level <= '0;
    end else begin
      level <= level + {3'b000, push} - {3'b000, serial_valid && serial_ready};
    end
  end

  // stalled response channels hold their payload
  assert property (@(posedge clock) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(b_payload))
    else $error("B payload changed while stalled");

  assert property (@(posedge clock) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(r_payload))
    else $error("R payload changed while stalled");

  assert property (@(posedge clock) disable iff (rst)
    serial_valid && !serial_ready |=> serial_valid && $stable(serial_data))
    else $error("serial byte changed while stalled");

  // no new address while a response is pending
  assert property (@(posedge clock) disable iff (rst)
    (bvalid || rvalid) |-> !(awready || arready))
    else $error("address ready during a response");

  assert property (@(posedge clock) disable iff (rst)
    serial_valid |-> (level != '0))
    else $error("serial valid with an empty fifo");

  assert property (@(posedge clock) disable iff (rst)
    full |-> !push)
    else $error("push into a full fifo");

endmodule

bind axi_slave_port npc_soc_chk chk_port (
  .clock        (clock),
  .rst          (rst),
  .awready      (awready),
  .arready      (arready),
  .bvalid       (bvalid),
  .bready       (bready),
  .b_payload    ({bid, bresp}),
  .rvalid       (rvalid),
  .rready       (rready),
  .r_payload    ({rid, rdata, rresp, rlast}),
  .push         (1'b0),
  .full         (1'b0),
  .serial_valid (1'b0),
  .serial_ready (1'b0),
  .serial_data  (8'h00)
);

bind serial_out_fifo npc_soc_chk chk_fifo (
  .clock        (clock),
  .rst          (rst),
  .awready      (1'b0),
  .arready      (1'b0),
  .bvalid       (1'b0),
  .bready       (1'b0),
  .b_payload    (6'h00),
  .rvalid       (1'b0),
  .rready       (1'b0),
  .r_payload    (39'h0),
  .push         (push),
  .full         (full),
  .serial_valid (serial_valid),
  .serial_ready (serial_ready),
  .serial_data  (serial_data)
);

//--- sim/npc_soc_tb.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module npc_soc_tb
  import soc_pkg::*;
();

  localparam addr_t mem_base  = `SOC_MEM_BASE;
  localparam int    mem_words = `SOC_MEM_WORDS;
  localparam addr_t ser_addr  = `SOC_SERIAL_ADDR;
  localparam addr_t hole_base = 32'h4000_0000;
  localparam int    timeout_cycles = 20000;

  logic clock;
  logic rst;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast;
  logic serial_valid, serial_ready;
  logic [2:0] awsize, arsize;
  logic [1:0] awburst, arburst;
  axi_id_t    awid, bid, arid, rid;
  addr_t      awaddr, araddr;
  axi_len_t   awlen, arlen;
  data_t      wdata, rdata;
  strb_t      wstrb;
  axi_resp_t  bresp, rresp;
  byte_t      serial_data;

  logic gaps_on;
  logic ser_slow;
  int   cycles;

  // reference memory image and expected responses
  data_t     ref_mem [int];
  byte_t     exp_bytes [$];
  data_t     exp_rdata [$];
  axi_resp_t exp_rresp [$];
  logic      exp_rlast [$];
  axi_id_t   exp_rid [$];
  axi_id_t   exp_bid [$];
  axi_resp_t exp_bresp [$];

  npc_soc_top UUT (.*);

  always #20 clock = ~clock;

  function automatic logic in_mem(addr_t a);
    return (a >= mem_base) && (a < mem_base + addr_t'(mem_words * 4));
  endfunction

  function automatic logic in_serial(addr_t a);
    return a[31:2] == ser_addr[31:2];
  endfunction

  // applies a strobed write and returns its response
  function automatic axi_resp_t ref_write(addr_t a, data_t d, strb_t s);
    data_t w;
    int    idx;
    idx = int'((a - mem_base) >> 2);
    if (in_mem(a)) begin
      w = ref_mem.exists(idx) ? ref_mem[idx] : '0;
      for (int lane = 0; lane < 4; lane++) begin
        if (s[lane]) w[8*lane +: 8] = d[8*lane +: 8];
      end
      ref_mem[idx] = w;
      return resp_okay;
    end
    if (in_serial(a)) begin
      if (s[0]) exp_bytes.push_back(d[7:0]);
      return resp_okay;
    end
    return resp_slverr;
  endfunction

  function automatic data_t ref_read(addr_t a, output axi_resp_t r);
    r = resp_okay;
    if (in_mem(a)) return ref_mem[int'((a - mem_base) >> 2)];
    if (!in_serial(a)) r = resp_slverr;
    return '0;
  endfunction

  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_data(string what, data_t got, data_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s expected %h got %h", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_resp(string what, axi_resp_t got, axi_resp_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s expected %h got %h", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_id(string what, axi_id_t got, axi_id_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s expected %h got %h", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s expected %b got %b", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_byte(string what, byte_t got, byte_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s expected %h got %h", $time, what, exp, got);
      stop_run();
    end
  endtask

  // compare every handshake as it happens
  always @(posedge clock) begin
    if (!rst && rvalid && rready) begin
      if (exp_rdata.size() == 0) begin
        $display("R beat arrived with no read outstanding");
        stop_run();
      end
      check_data("rdata", rdata, exp_rdata.pop_front());
      check_resp("rresp", rresp, exp_rresp.pop_front());
      check_flag("rlast", rlast, exp_rlast.pop_front());
      check_id("rid", rid, exp_rid.pop_front());
    end
    if (!rst && bvalid && bready) begin
      if (exp_bid.size() == 0) begin
        $display("B response arrived with no write outstanding");
        stop_run();
      end
      check_id("bid", bid, exp_bid.pop_front());
      check_resp("bresp", bresp, exp_bresp.pop_front());
    end
    if (!rst && serial_valid && serial_ready) begin
      if (exp_bytes.size() == 0) begin
        $display("serial byte came out that was never written");
        stop_run();
      end
      check_byte("serial byte", serial_data, exp_bytes.pop_front());
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      stop_run();
    end
  end

  // ready gaps on the response channels and the serial sink
  always @(negedge clock) begin
    rready = gaps_on ? ($urandom_range(0, 3) != 0) : 1'b1;
    bready = gaps_on ? ($urandom_range(0, 3) != 0) : 1'b1;
    serial_ready = ser_slow ? ($urandom_range(0, 7) == 0) : 1'b1;
  end

  task automatic write_burst(addr_t a, axi_len_t len, axi_id_t id, logic full_strb);
    data_t     dv [$];
    strb_t     sv [$];
    axi_resp_t r;
    r = resp_okay;
    for (int i = 0; i <= int'(len); i++) begin
      dv.push_back($urandom);
      sv.push_back(full_strb ? 4'hf : strb_t'($urandom));
      r = r | ref_write(a + addr_t'(4 * i), dv[i], sv[i]);
    end
    exp_bid.push_back(id);
    exp_bresp.push_back(r);
    @(negedge clock);
    awvalid = 1'b1;
    awaddr  = a;
    awlen   = len;
    awid    = id;
    #1;
    while (!awready) begin
      @(negedge clock);
      #1;
    end
    for (int i = 0; i <= int'(len); i++) begin
      @(negedge clock);
      awvalid = 1'b0;
      wvalid  = 1'b1;
      wdata   = dv[i];
      wstrb   = sv[i];
      wlast   = (i == int'(len));
      #1;
      while (!wready) begin
        @(negedge clock);
        #1;
      end
    end
    @(negedge clock);
    wvalid = 1'b0;
    wlast  = 1'b0;
    while (exp_bid.size() != 0) @(negedge clock);
  endtask

  task automatic read_burst(addr_t a, axi_len_t len, axi_id_t id);
    axi_resp_t r;
    data_t     d;
    for (int i = 0; i <= int'(len); i++) begin
      d = ref_read(a + addr_t'(4 * i), r);
      exp_rdata.push_back(d);
      exp_rresp.push_back(r);
      exp_rlast.push_back(i == int'(len));
      exp_rid.push_back(id);
    end
    @(negedge clock);
    arvalid = 1'b1;
    araddr  = a;
    arlen   = len;
    arid    = id;
    #1;
    while (!arready) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    arvalid = 1'b0;
    while (exp_rdata.size() != 0) @(negedge clock);
  endtask

  function automatic addr_t mem_addr(int top);
    return mem_base + addr_t'(4 * $urandom_range(0, top));
  endfunction

  initial begin
    addr_t    a;
    addr_t    kept;
    axi_len_t len;
    void'($urandom(32'h2b38_c037));
    clock = 1'b0;
    rst = 1'b1;
    cycles = 0;
    gaps_on = 1'b0;
    ser_slow = 1'b0;
    {awvalid, wvalid, wlast, arvalid} = '0;
    {rready, bready, serial_ready} = 3'b111;
    {awaddr, araddr, wdata} = '0;
    {awid, arid, awlen, arlen, wstrb} = '0;
    awsize = 3'd2;
    arsize = 3'd2;
    awburst = 2'b01;
    arburst = 2'b01;
    repeat (3) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    // single beats, then partial strobes over a known word
    repeat (8) begin
      kept = mem_addr(255);
      write_burst(kept, 8'd0, axi_id_t'($urandom), 1'b1);
      read_burst(kept, 8'd0, axi_id_t'($urandom));
    end
    repeat (8) begin
      a = mem_addr(255);
      write_burst(a, 8'd0, axi_id_t'($urandom), 1'b1);
      write_burst(a, 8'd0, axi_id_t'($urandom), 1'b0);
      read_burst(a, 8'd0, axi_id_t'($urandom));
    end
    repeat (10) begin
      len = axi_len_t'($urandom_range(0, 15));
      a = mem_addr(900);
      write_burst(a, len, axi_id_t'($urandom), 1'b1);
      read_burst(a, len, axi_id_t'($urandom));
    end
    // unmapped space at the same word offset as a live memory word
    repeat (4) begin
      len = axi_len_t'($urandom_range(0, 3));
      a = hole_base + (kept - mem_base);
      write_burst(a, len, axi_id_t'($urandom), 1'b1);
      read_burst(a, len, axi_id_t'($urandom));
      read_burst(kept, 8'd0, axi_id_t'($urandom));
    end
    ser_slow = 1'b1;
    repeat (24) begin
      write_burst(ser_addr, 8'd0, axi_id_t'($urandom), 1'b0);
    end
    while (exp_bytes.size() != 0) @(negedge clock);
    ser_slow = 1'b0;
    gaps_on = 1'b1;
    repeat (10) begin
      len = axi_len_t'($urandom_range(0, 15));
      a = mem_addr(900);
      write_burst(a, len, axi_id_t'($urandom), $urandom_range(0, 1) == 1);
      read_burst(a, len, axi_id_t'($urandom));
    end
    gaps_on = 1'b0;
    repeat (4) @(negedge clock);
    $display("Finished with no errors");
    $finish;
  end

endmodule
